/* design/simt_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SIMT datapath widths
// Word, register index and tag sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package simt_pkg;

    localparam int unsigned xlen      = 32;
    localparam int unsigned nr_bits   = 5;   // Destination register index
    localparam int unsigned uuid_bits = 8;   // Instruction tag

    // Shift amount taken from operand B
    localparam int unsigned shamt_bits = $clog2(xlen);

    // Index width for a table of n entries, never below one bit
    function automatic int unsigned idx_bits(int unsigned n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

/* design/int_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ISA definitions
// Operation word views, op classes and lane selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package int_isa_pkg;

    // One 4-bit operation word, read as ALU op or as branch op
    typedef union packed {
        struct packed {
            logic [1:0] op_class;
            logic [1:0] func;
        } alu;
        struct packed {
            logic br_static;  // JAL / JALR
            logic br_less;    // Compare on less, else on equal
            logic br_neg;     // Invert the condition
            logic br_signed;
        } br;
    } int_op_u;

    // Op classes, upper half of the ALU view
    localparam logic [1:0] CLS_ADD = 2'b00;
    localparam logic [1:0] CLS_SUB = 2'b01;
    localparam logic [1:0] CLS_SHR = 2'b10;
    localparam logic [1:0] CLS_MSC = 2'b11;

    // ALU operations
    localparam int_op_u OP_ADD  = {CLS_ADD, 2'b00};
    localparam int_op_u OP_SUB  = {CLS_SUB, 2'b00};
    localparam int_op_u OP_SLTU = {CLS_SUB, 2'b10};
    localparam int_op_u OP_SLT  = {CLS_SUB, 2'b11};
    localparam int_op_u OP_SRL  = {CLS_SHR, 2'b00};
    localparam int_op_u OP_SRA  = {CLS_SHR, 2'b01};
    localparam int_op_u OP_AND  = {CLS_MSC, 2'b00};
    localparam int_op_u OP_OR   = {CLS_MSC, 2'b01};
    localparam int_op_u OP_XOR  = {CLS_MSC, 2'b10};
    localparam int_op_u OP_SLL  = {CLS_MSC, 2'b11};

    // Branch operations, {static, less, neg, signed}
    localparam int_op_u BR_BEQ  = 4'b0000;
    localparam int_op_u BR_BNE  = 4'b0010;
    localparam int_op_u BR_BLT  = 4'b0101;
    localparam int_op_u BR_BGE  = 4'b0111;
    localparam int_op_u BR_BLTU = 4'b0100;
    localparam int_op_u BR_BGEU = 4'b0110;
    localparam int_op_u BR_JAL  = 4'b1000;
    localparam int_op_u BR_JALR = 4'b1001;

    // Result select inside one lane
    typedef enum logic [2:0] {
        LS_ADD,
        LS_SUB,
        LS_CMP,  // bit 0 less, bit 1 equal
        LS_SHR,
        LS_MSC
    } lane_sel_e;

endpackage

/* design/int_alu_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU lane
// Add, compare, shift and logic for one thread
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module int_alu_lane
    import simt_pkg::*;
    import int_isa_pkg::*;
(
    input  lane_sel_e       lane_sel,
    input  logic [1:0]      func,
    input  logic            is_signed,
    input  logic [xlen-1:0] in_a,
    input  logic [xlen-1:0] in_b,
    output logic [xlen-1:0] result
);

    logic [xlen-1:0] sum;
    logic [xlen:0]   diff;      // One extra bit carries the compare sign
    logic [xlen:0]   shr_wide;
    logic [xlen-1:0] msc;
    logic            less;
    logic            equal;

    assign sum = in_a + in_b;

    // Sign extension only for signed compares, so bit xlen is always the sign
    assign diff = {is_signed & in_a[xlen-1], in_a} - {is_signed & in_b[xlen-1], in_b};

    assign less  = diff[xlen];
    assign equal = ~|diff[xlen-1:0];

    assign shr_wide = $signed({is_signed & in_a[xlen-1], in_a}) >>> in_b[shamt_bits-1:0];

    always_comb begin
        case (func)
            2'b00:   msc = in_a & in_b;
            2'b01:   msc = in_a | in_b;
            2'b10:   msc = in_a ^ in_b;
            default: msc = in_a << in_b[shamt_bits-1:0];  // SLL
        endcase
    end

    always_comb begin
        case (lane_sel)
            LS_ADD: result = sum;
            LS_SUB: begin
                // func[1] picks SLT / SLTU over plain SUB
                if (func[1]) begin
                    result = {{(xlen-1){1'b0}}, less};
                end else begin
                    result = diff[xlen-1:0];
                end
            end
            LS_CMP:  result = {{(xlen-2){1'b0}}, equal, less};
            LS_SHR:  result = shr_wide[xlen-1:0];
            LS_MSC:  result = msc;
            default: result = '0;
        endcase
    end

    // Select comes from the decoder in int_unit, must always be driven
    always_comb begin
        assert final (!$isunknown(lane_sel))
        else $error("int_alu_lane: lane_sel is unknown");
    end

endmodule

/* design/elastic_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Elastic buffer
// Two-entry valid/ready skid stage, registered output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module elastic_buffer #(
    parameter int DATAW = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             out_free;    // Output slot empty or draining this cycle
    logic             push;

    assign out_free = !valid_out || ready_out;
    assign push     = valid_in && ready_in;
    assign ready_in = !skid_valid;  // Full only with both slots taken

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            valid_out  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;  // Output stalled, park the new item
        end
    end

    // Skid entry always drains first to keep order
    always_ff @(posedge clk) begin
        if (out_free && skid_valid) begin
            data_out <= skid_data;
        end else if (out_free && push) begin
            data_out <= data_in;
        end
        if (!out_free && push) begin
            skid_data <= data_in;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> valid_out && $stable(data_out))
    else $error("elastic_buffer: output changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        skid_valid && !ready_out |=> skid_valid && $stable(skid_data))
    else $error("elastic_buffer: write into a full buffer");

endmodule

/* design/int_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute unit
// Lane ALUs, commit buffer and branch resolution
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module int_unit
    import simt_pkg::*;
    import int_isa_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int NUM_WARPS = 4,
    localparam int lane_bits = idx_bits(NUM_LANES),
    localparam int wid_bits  = idx_bits(NUM_WARPS)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           exe_valid,
    output logic                           exe_ready,
    input  logic [uuid_bits-1:0]           exe_uuid,
    input  logic [wid_bits-1:0]            exe_wid,
    input  logic [NUM_LANES-1:0]           exe_tmask,
    input  logic [nr_bits-1:0]             exe_rd,
    input  logic                           exe_wb,
    input  logic                           exe_eop,
    input  int_op_u                        exe_op,
    input  logic                           exe_is_br,
    input  logic                           exe_use_pc,
    input  logic                           exe_use_imm,
    input  logic [xlen-1:0]                exe_pc,
    input  logic [xlen-1:0]                exe_imm,
    input  logic [NUM_LANES-1:0][xlen-1:0] exe_rs1_data,
    input  logic [NUM_LANES-1:0][xlen-1:0] exe_rs2_data,
    input  logic [lane_bits-1:0]           exe_tid,
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [uuid_bits-1:0]           commit_uuid,
    output logic [wid_bits-1:0]            commit_wid,
    output logic [NUM_LANES-1:0]           commit_tmask,
    output logic [nr_bits-1:0]             commit_rd,
    output logic                           commit_wb,
    output logic                           commit_eop,
    output logic [NUM_LANES-1:0][xlen-1:0] commit_data,
    output logic [xlen-1:0]                commit_pc,
    output logic                           branch_valid,
    output logic [wid_bits-1:0]            branch_wid,
    output logic                           branch_taken,
    output logic [xlen-1:0]                branch_dest
);

    localparam int buf_dataw = uuid_bits + wid_bits + NUM_LANES + nr_bits + 2
                             + NUM_LANES * xlen + 2 * xlen + 1 + $bits(int_op_u) + lane_bits;

    lane_sel_e                      lane_sel;
    logic                           is_signed;
    logic                           is_cond_br;
    logic [NUM_LANES-1:0][xlen-1:0] alu_result;
    logic [NUM_LANES-1:0][xlen-1:0] alu_result_r;
    logic [xlen-1:0]                pc_r;
    logic [xlen-1:0]                imm_r;
    logic                           is_br_r;
    int_op_u                        op_r;
    logic [lane_bits-1:0]           tid_r;
    logic [xlen-1:0]                br_result;
    logic                           br_fire;
    logic                           br_taken;
    logic [xlen-1:0]                br_dest;

    assign is_cond_br = exe_is_br && !exe_op.br.br_static;

    always_comb begin
        if (exe_is_br) begin
            lane_sel  = exe_op.br.br_static ? LS_ADD : LS_CMP;  // Jumps add the target
            is_signed = exe_op.br.br_signed;
        end else begin
            is_signed = exe_op.alu.func[0];  // SLT and SRA
            case (exe_op.alu.op_class)
                CLS_ADD: lane_sel = LS_ADD;
                CLS_SUB: lane_sel = LS_SUB;
                CLS_SHR: lane_sel = LS_SHR;
                default: lane_sel = LS_MSC;
            endcase
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [xlen-1:0] in_a;
        logic [xlen-1:0] in_b;

        assign in_a = exe_use_pc ? exe_pc : exe_rs1_data[i];
        // Conditional branches compare registers, imm goes to the target add
        assign in_b = (exe_use_imm && !is_cond_br) ? exe_imm : exe_rs2_data[i];

        int_alu_lane u_lane (
            .lane_sel  (lane_sel),
            .func      (exe_op.alu.func),
            .is_signed (is_signed),
            .in_a      (in_a),
            .in_b      (in_b),
            .result    (alu_result[i])
        );
    end

    elastic_buffer #(
        .DATAW (buf_dataw)
    ) u_rsp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (exe_valid),
        .data_in   ({exe_uuid, exe_wid, exe_tmask, exe_rd, exe_wb, exe_eop, alu_result,
                     exe_pc, exe_imm, exe_is_br, exe_op, exe_tid}),
        .ready_in  (exe_ready),
        .valid_out (commit_valid),
        .data_out  ({commit_uuid, commit_wid, commit_tmask, commit_rd, commit_wb, commit_eop,
                     alu_result_r, pc_r, imm_r, is_br_r, op_r, tid_r}),
        .ready_out (commit_ready)
    );

    // Lane tid decides for the whole warp
    assign br_result = alu_result_r[tid_r];
    assign br_fire   = is_br_r && commit_valid && commit_ready && commit_eop;
    assign br_taken  = ((op_r.br.br_less ? br_result[0] : br_result[1]) ^ op_r.br.br_neg)
                     | op_r.br.br_static;
    assign br_dest   = op_r.br.br_static ? br_result : pc_r + imm_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_valid <= 1'b0;
        end else begin
            branch_valid <= br_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (br_fire) begin
            branch_wid   <= commit_wid;
            branch_taken <= br_taken;
            branch_dest  <= br_dest;
        end
    end

    // Jumps write the link address in every lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            commit_data[i] = (is_br_r && op_r.br.br_static) ? pc_r + 32'd4 : alu_result_r[i];
        end
    end

    assign commit_pc = pc_r;

    assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid |-> exe_tid < NUM_LANES)
    else $error("int_unit: branch lane %0d out of range", exe_tid);

endmodule

/* design/warp_pc_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Warp PC table
// Next-PC per warp, updated by taken branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module warp_pc_table
    import simt_pkg::*;
#(
    parameter int NUM_WARPS = 4,
    localparam int wid_bits = idx_bits(NUM_WARPS)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                branch_valid,
    input  logic [wid_bits-1:0] branch_wid,
    input  logic                branch_taken,
    input  logic [xlen-1:0]     branch_dest,
    input  logic [wid_bits-1:0] pc_rd_wid,
    output logic [xlen-1:0]     pc_rd_data
);

    logic [xlen-1:0] pc_tbl [NUM_WARPS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                pc_tbl[w] <= '0;
            end
        end else if (branch_valid && branch_taken) begin
            pc_tbl[branch_wid] <= branch_dest;  // Not-taken keeps the old target
        end
    end

    assign pc_rd_data = pc_tbl[pc_rd_wid];  // Combinational read

    // Warp id comes from the commit side of int_unit
    assert property (@(posedge clk) disable iff (!rst_n)
        branch_valid |-> branch_wid < NUM_WARPS)
    else $error("warp_pc_table: branch for warp %0d out of range", branch_wid);

endmodule

/* design/int_exec_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute top
// Execute unit feeding the warp PC table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module int_exec_top
    import simt_pkg::*;
    import int_isa_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int NUM_WARPS = 4,
    localparam int lane_bits = idx_bits(NUM_LANES),
    localparam int wid_bits  = idx_bits(NUM_WARPS)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           exe_valid,
    output logic                           exe_ready,
    input  logic [uuid_bits-1:0]           exe_uuid,
    input  logic [wid_bits-1:0]            exe_wid,
    input  logic [NUM_LANES-1:0]           exe_tmask,
    input  logic [nr_bits-1:0]             exe_rd,
    input  logic                           exe_wb,
    input  logic                           exe_eop,
    input  int_op_u                        exe_op,
    input  logic                           exe_is_br,
    input  logic                           exe_use_pc,
    input  logic                           exe_use_imm,
    input  logic [xlen-1:0]                exe_pc,
    input  logic [xlen-1:0]                exe_imm,
    input  logic [NUM_LANES-1:0][xlen-1:0] exe_rs1_data,
    input  logic [NUM_LANES-1:0][xlen-1:0] exe_rs2_data,
    input  logic [lane_bits-1:0]           exe_tid,
    output logic                           commit_valid,
    input  logic                           commit_ready,
    output logic [uuid_bits-1:0]           commit_uuid,
    output logic [wid_bits-1:0]            commit_wid,
    output logic [NUM_LANES-1:0]           commit_tmask,
    output logic [nr_bits-1:0]             commit_rd,
    output logic                           commit_wb,
    output logic                           commit_eop,
    output logic [NUM_LANES-1:0][xlen-1:0] commit_data,
    output logic [xlen-1:0]                commit_pc,
    output logic                           branch_valid,
    output logic [wid_bits-1:0]            branch_wid,
    output logic                           branch_taken,
    output logic [xlen-1:0]                branch_dest,
    input  logic [wid_bits-1:0]            pc_rd_wid,
    output logic [xlen-1:0]                pc_rd_data
);

    // Port names match one to one
    int_unit #(
        .NUM_LANES (NUM_LANES),
        .NUM_WARPS (NUM_WARPS)
    ) u_int_unit (.*);

    // Branch message is shared with the top outputs
    warp_pc_table #(
        .NUM_WARPS (NUM_WARPS)
    ) u_pc_table (.*);

endmodule

/* verif/int_ref_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute reference model
// Expected lane words, branch outcome and target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef INT_REF_MODEL_SVH
`define INT_REF_MODEL_SVH

function automatic bit ref_is_jump(int_op_u op);
    return (op == BR_JAL) || (op == BR_JALR);
endfunction

// RV32I semantics, shift amount from the low five bits
function automatic logic [xlen-1:0] ref_alu(int_op_u op, logic [xlen-1:0] a,
                                             logic [xlen-1:0] b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_SLT:  return xlen'($signed(a) < $signed(b));
        OP_SLTU: return xlen'(a < b);
        OP_SRL:  return a >> b[4:0];
        OP_SRA:  return $signed(a) >>> b[4:0];
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLL:  return a << b[4:0];
        default: return 'x;
    endcase
endfunction

// Compare word of a conditional branch
function automatic logic [xlen-1:0] ref_cmp_word(int_op_u op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
    logic less;
    if (op == BR_BLT || op == BR_BGE) begin
        less = $signed(a) < $signed(b);
    end else begin
        less = a < b;
    end
    return {{(xlen-2){1'b0}}, a == b, less};  // Bit 1 equal, bit 0 less
endfunction

function automatic logic [xlen-1:0] ref_commit_word(int_op_u op, bit is_br, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b, logic [xlen-1:0] pc);
    if (!is_br) begin
        return ref_alu(op, a, b);
    end
    if (ref_is_jump(op)) begin
        return pc + 32'd4;  // Link address
    end
    return ref_cmp_word(op, a, b);
endfunction

function automatic bit ref_br_taken(int_op_u op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (op)
        BR_BEQ:  return a == b;
        BR_BNE:  return a != b;
        BR_BLT:  return $signed(a) < $signed(b);
        BR_BGE:  return $signed(a) >= $signed(b);
        BR_BLTU: return a < b;
        BR_BGEU: return a >= b;
        default: return 1'b1;  // Jumps
    endcase
endfunction

// JALR goes register relative, all others PC relative
function automatic logic [xlen-1:0] ref_br_dest(int_op_u op, logic [xlen-1:0] pc,
                                                 logic [xlen-1:0] imm, logic [xlen-1:0] rs1);
    return (op == BR_JALR) ? rs1 + imm : pc + imm;
endfunction

`endif

/* verif/tb_int_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute testbench
// Table stimulus, in-order scoreboard, branch and PC checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_int_exec
    import simt_pkg::*;
    import int_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES  = 4;
    localparam int NUM_WARPS  = 4;
    localparam int lane_bits  = $clog2(NUM_LANES);
    localparam int wid_bits   = $clog2(NUM_WARPS);
    localparam int rst_cycles = 10;
    localparam int max_tests  = 48;
    localparam int snap_w     = uuid_bits + wid_bits + NUM_LANES + nr_bits + 2
                              + (NUM_LANES + 1) * xlen;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           exe_valid;
    logic                           exe_ready;
    logic [uuid_bits-1:0]           exe_uuid;
    logic [wid_bits-1:0]            exe_wid;
    logic [NUM_LANES-1:0]           exe_tmask;
    logic [nr_bits-1:0]             exe_rd;
    logic                           exe_wb;
    logic                           exe_eop;
    int_op_u                        exe_op;
    logic                           exe_is_br;
    logic                           exe_use_pc;
    logic                           exe_use_imm;
    logic [xlen-1:0]                exe_pc;
    logic [xlen-1:0]                exe_imm;
    logic [NUM_LANES-1:0][xlen-1:0] exe_rs1_data;
    logic [NUM_LANES-1:0][xlen-1:0] exe_rs2_data;
    logic [lane_bits-1:0]           exe_tid;
    logic                           commit_valid;
    logic                           commit_ready;
    logic [uuid_bits-1:0]           commit_uuid;
    logic [wid_bits-1:0]            commit_wid;
    logic [NUM_LANES-1:0]           commit_tmask;
    logic [nr_bits-1:0]             commit_rd;
    logic                           commit_wb;
    logic                           commit_eop;
    logic [NUM_LANES-1:0][xlen-1:0] commit_data;
    logic [xlen-1:0]                commit_pc;
    logic                           branch_valid;
    logic [wid_bits-1:0]            branch_wid;
    logic                           branch_taken;
    logic [xlen-1:0]                branch_dest;
    logic [wid_bits-1:0]            pc_rd_wid;
    logic [xlen-1:0]                pc_rd_data;

    // Stimulus table with expected results
    string                          t_name      [max_tests];
    int_op_u                        t_op        [max_tests];
    bit                             t_is_br     [max_tests];
    bit                             t_use_pc    [max_tests];
    bit                             t_use_imm   [max_tests];
    bit                             t_eop       [max_tests];
    logic [xlen-1:0]                t_pc        [max_tests];
    logic [xlen-1:0]                t_imm       [max_tests];
    logic [NUM_LANES-1:0][xlen-1:0] t_rs1       [max_tests];
    logic [NUM_LANES-1:0][xlen-1:0] t_rs2       [max_tests];
    logic [NUM_LANES-1:0]           t_tmask     [max_tests];
    logic [lane_bits-1:0]           t_tid       [max_tests];
    logic [wid_bits-1:0]            t_wid       [max_tests];
    logic [NUM_LANES-1:0][xlen-1:0] t_exp_data  [max_tests];
    bit                             t_exp_taken [max_tests];
    logic [xlen-1:0]                t_exp_dest  [max_tests];
    int                             n_tests = 0;

    int              sb_q [$];        // Table indexes in issue order
    logic [xlen-1:0] exp_pc [NUM_WARPS];
    logic [31:0]     rng_state = 32'd75278;
    int              val_errs = 0;
    int              proto_errs = 0;
    int              n_commits = 0;
    bit              br_pend = 1'b0;
    int              br_idx;
    bit              hold_flag = 1'b0;
    logic [snap_w-1:0] hold_snap;

    `include "int_ref_model.svh"

    int_exec_top #(
        .NUM_LANES (NUM_LANES),
        .NUM_WARPS (NUM_WARPS)
    ) uut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic add_entry(string name, int_op_u op, bit is_br, bit use_pc, bit use_imm,
                             bit eop, bit same_ops);
        int              n;
        logic [31:0]     r;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        n = n_tests;
        r = next_rand();
        t_name[n]    = name;
        t_op[n]      = op;
        t_is_br[n]   = is_br;
        t_use_pc[n]  = use_pc;
        t_use_imm[n] = use_imm;
        t_eop[n]     = eop;
        t_pc[n]      = next_rand() & 32'hffff_fffc;  // Word aligned
        t_imm[n]     = next_rand();
        t_tmask[n]   = r[NUM_LANES-1:0];
        t_tid[n]     = r[8 +: lane_bits];
        t_wid[n]     = r[16 +: wid_bits];
        for (int l = 0; l < NUM_LANES; l++) begin
            t_rs1[n][l] = next_rand();
            t_rs2[n][l] = same_ops ? t_rs1[n][l] : next_rand();
            a = use_pc ? t_pc[n] : t_rs1[n][l];
            // Conditional branches compare against rs2
            b = (use_imm && !(is_br && !ref_is_jump(op))) ? t_imm[n] : t_rs2[n][l];
            t_exp_data[n][l] = ref_commit_word(op, is_br, a, b, t_pc[n]);
        end
        t_exp_taken[n] = ref_br_taken(op, t_rs1[n][t_tid[n]], t_rs2[n][t_tid[n]]);
        t_exp_dest[n]  = ref_br_dest(op, t_pc[n], t_imm[n], t_rs1[n][t_tid[n]]);
        n_tests++;
    endtask

    // Register, immediate and PC as operand A
    task automatic add_alu_set(string name, int_op_u op);
        add_entry({name, " reg"}, op, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        add_entry({name, " imm"}, op, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        add_entry({name, " pc"}, op, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic add_branch_pair(string name, int_op_u op);
        add_entry(name, op, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        add_entry({name, " equal"}, op, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic build_table();
        add_alu_set("ADD", OP_ADD);
        add_alu_set("SUB", OP_SUB);
        add_alu_set("SLT", OP_SLT);
        add_alu_set("SLTU", OP_SLTU);
        add_alu_set("SRL", OP_SRL);
        add_alu_set("SRA", OP_SRA);
        add_alu_set("AND", OP_AND);
        add_alu_set("OR", OP_OR);
        add_alu_set("XOR", OP_XOR);
        add_alu_set("SLL", OP_SLL);
        add_branch_pair("BEQ", BR_BEQ);
        add_branch_pair("BNE", BR_BNE);
        add_branch_pair("BLT", BR_BLT);
        add_branch_pair("BGE", BR_BGE);
        add_branch_pair("BLTU", BR_BLTU);
        add_branch_pair("BGEU", BR_BGEU);
        add_entry("JAL", BR_JAL, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        add_entry("JALR", BR_JALR, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        add_entry("JAL no eop", BR_JAL, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);  // No strobe expected
        add_entry("BEQ no eop", BR_BEQ, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
    endtask

    task automatic drive_entry(int i);
        exe_valid    <= 1'b1;
        exe_uuid     <= i[7:0];
        exe_wid      <= t_wid[i];
        exe_tmask    <= t_tmask[i];
        exe_rd       <= i[4:0];
        exe_wb       <= i[0];
        exe_eop      <= t_eop[i];
        exe_op       <= t_op[i];
        exe_is_br    <= t_is_br[i];
        exe_use_pc   <= t_use_pc[i];
        exe_use_imm  <= t_use_imm[i];
        exe_pc       <= t_pc[i];
        exe_imm      <= t_imm[i];
        exe_rs1_data <= t_rs1[i];
        exe_rs2_data <= t_rs2[i];
        exe_tid      <= t_tid[i];
    endtask

    task automatic check_val(string test, string field, logic [xlen-1:0] exp,
                             logic [xlen-1:0] act);
        assert (exp === act)
        else begin
            val_errs++;
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic check_pc();
        check_val("PC read", $sformatf("pc_rd_data[%0d]", pc_rd_wid), exp_pc[pc_rd_wid],
                  pc_rd_data);
    endtask

    task automatic check_branch();
        assert (branch_valid === br_pend)
        else begin
            proto_errs++;
            $display("Branch strobe was %0b one cycle after commit, expected %0b",
                     branch_valid, br_pend);
        end
        if (br_pend && branch_valid) begin
            check_val(t_name[br_idx], "branch_wid", 32'(t_wid[br_idx]), 32'(branch_wid));
            check_val(t_name[br_idx], "branch_taken", 32'(t_exp_taken[br_idx]),
                      32'(branch_taken));
            check_val(t_name[br_idx], "branch_dest", t_exp_dest[br_idx], branch_dest);
            if (t_exp_taken[br_idx]) begin
                exp_pc[t_wid[br_idx]] = t_exp_dest[br_idx];  // Table writes on the next edge
            end
        end
        br_pend = 1'b0;
    endtask

    task automatic check_hold();
        logic [snap_w-1:0] snap;
        snap = {commit_uuid, commit_wid, commit_tmask, commit_rd, commit_wb, commit_eop,
                commit_data, commit_pc};
        if (hold_flag) begin
            assert (commit_valid && snap === hold_snap)
            else begin
                proto_errs++;
                $display("Commit outputs changed while commit_ready was low");
            end
        end
        hold_flag = commit_valid && !commit_ready;
        hold_snap = snap;
    endtask

    task automatic check_commit();
        int idx;
        if (commit_valid && commit_ready) begin
            assert (sb_q.size() != 0)
            else begin
                proto_errs++;
                $display("Commit seen with no instruction outstanding");
            end
            if (sb_q.size() != 0) begin
                idx = sb_q.pop_front();
                n_commits++;
                check_val(t_name[idx], "uuid", 32'(idx[7:0]), 32'(commit_uuid));
                check_val(t_name[idx], "wid", 32'(t_wid[idx]), 32'(commit_wid));
                check_val(t_name[idx], "tmask", 32'(t_tmask[idx]), 32'(commit_tmask));
                check_val(t_name[idx], "rd", 32'(idx[4:0]), 32'(commit_rd));
                check_val(t_name[idx], "wb", 32'(idx[0]), 32'(commit_wb));
                check_val(t_name[idx], "eop", 32'(t_eop[idx]), 32'(commit_eop));
                check_val(t_name[idx], "pc", t_pc[idx], commit_pc);
                for (int l = 0; l < NUM_LANES; l++) begin
                    check_val(t_name[idx], $sformatf("data[%0d]", l), t_exp_data[idx][l],
                              commit_data[l]);
                end
                if (t_is_br[idx] && t_eop[idx]) begin
                    br_pend = 1'b1;
                    br_idx  = idx;
                end
            end
        end
    endtask

    // Sampled mid-cycle ahead of the handshake edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_pc();       // Ahead of the model update below
            check_branch();
            check_hold();
            check_commit();
        end
    end

    always @(posedge clk) begin
        commit_ready <= (next_rand() % 4) != 0;  // Roughly one stall in four
        pc_rd_wid    <= pc_rd_wid + wid_bits'(1);
    end

    initial begin
        int i;
        build_table();
        for (i = 0; i < NUM_WARPS; i++) begin
            exp_pc[i] = '0;
        end
        rst_n        = 1'b0;
        exe_valid    = 1'b0;
        exe_uuid     = '0;
        exe_wid      = '0;
        exe_tmask    = '0;
        exe_rd       = '0;
        exe_wb       = 1'b0;
        exe_eop      = 1'b0;
        exe_op       = '0;
        exe_is_br    = 1'b0;
        exe_use_pc   = 1'b0;
        exe_use_imm  = 1'b0;
        exe_pc       = '0;
        exe_imm      = '0;
        exe_rs1_data = '0;
        exe_rs2_data = '0;
        exe_tid      = '0;
        commit_ready = 1'b0;
        pc_rd_wid    = '0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!commit_valid && !branch_valid && exe_ready)
        else begin
            proto_errs++;
            $display("Wrong handshake levels after reset");
        end
        for (i = 0; i < n_tests; i++) begin
            @(posedge clk);
            drive_entry(i);
            do @(negedge clk); while (!exe_ready);
            sb_q.push_back(i);
        end
        @(posedge clk);
        exe_valid <= 1'b0;
        while (sb_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);  // Last strobe and PC update
        $display("Value errors: %0d, protocol errors: %0d, commits: %0d of %0d",
                 val_errs, proto_errs, n_commits, n_tests);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog allows twenty cycles per table entry after reset
    initial begin
        #1;
        repeat (rst_cycles + n_tests * 20) @(posedge clk);
        $display("Timeout with %0d of %0d instructions committed", n_commits, n_tests);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verif
design/simt_pkg.sv
design/int_isa_pkg.sv
design/int_alu_lane.sv
design/elastic_buffer.sv
design/int_unit.sv
design/warp_pc_table.sv
design/int_exec_top.sv
verif/tb_int_exec.sv

/* Makefile */
# Verilator build and run for the integer execute stage

VERILATOR ?= verilator
TOP       ?= tb_int_exec
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
